// ==== dv/stq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_tb
  import stq_cfg_pkg::*, stq_types_pkg::*;
();
  localparam int N = 8;
  localparam int TEST_CYCLES = 200 + 400 + 100; // Directed, random, final drain
  localparam stq_addr_t NO_A = '0;
  localparam ld_req_t NO_LD = '0;

  logic clk = 1'b0;
  logic rst, st_alloc_en, full, st_data_en, commit_en, excpt, drain_req, drain_ack;
  stq_addr_t st_alloc_addr;
  logic [2:0] st_alloc_idx, st_data_idx;
  logic [STQ_DATA_W-1:0] st_data;
  ld_req_t ld_req [LD_PORTS];
  ld_rsp_t ld_rsp [LD_PORTS];
  drain_pkt_t drain_pkt;

  // Queue mirror, updated on the same edges as the DUT
  stq_state_t m_st [N];
  stq_addr_t m_addr [N];
  logic [STQ_DATA_W-1:0] m_data [N];
  logic [3:0] m_head, m_cmt, m_tail;
  ld_rsp_t exp_q [LD_PORTS];
  logic chk_on, req_q, ack_q;
  int errors, drained;
  int idx_q [$]; // Committed entries in drain order
  string test_name;

  stq_top #(.NUM_ENTRIES(N)) stq_top_i (.*);

  always #2 clk = ~clk;

  // Youngest busy overlapping store decides hit or stall
  function automatic ld_rsp_t expect_rsp(input ld_req_t r);
    ld_rsp_t x;
    int e;
    x = '0;
    x.valid = r.en;
    for (int i = 0; i < N; i++) begin
      e = (m_tail - 1 - i) & (N - 1);
      if (r.en && m_st[e].busy && r.addr.addr == m_addr[e].addr &&
          |(r.addr.bytes & m_addr[e].bytes)) begin
        if (m_st[e].data_ok && (r.addr.bytes & ~m_addr[e].bytes) == '0) begin
          x.hit  = 1'b1;
          x.data = m_data[e];
        end else begin
          x.stall = 1'b1;
        end
        return x;
      end
    end
    return x;
  endfunction

  // Full once every entry holds a store
  function automatic logic all_busy();
    logic b;
    b = 1'b1;
    for (int e = 0; e < N; e++) begin
      b = b && m_st[e].busy;
    end
    return b;
  endfunction

  always @(posedge clk) begin : model
    stq_state_t st [N];
    logic [3:0] c, t, h;
    st = m_st;
    c = m_cmt;
    t = m_tail;
    h = m_head;
    for (int p = 0; p < LD_PORTS; p++) exp_q[p] <= expect_rsp(ld_req[p]);
    if (rst) begin
      st = '{default: '0};
      c = '0;
      t = '0;
      h = '0;
      idx_q.delete();
      chk_on <= 1'b0;
    end else begin
      chk_on <= 1'b1;
      if (commit_en && c != t) begin // Commit lands before a same-cycle exception
        st[c[2:0]].committed = 1'b1;
        idx_q.push_back(c[2:0]);
        c++;
      end
      if (st_data_en) begin
        st[st_data_idx].data_ok = 1'b1;
        m_data[st_data_idx] <= st_data;
      end
      if (excpt) begin
        for (int e = 0; e < N; e++) if (!st[e].committed) st[e].busy = 1'b0;
        t = c;
      end else if (st_alloc_en) begin
        st[t[2:0]] = 3'b100;
        m_addr[t[2:0]] <= st_alloc_addr;
        t++;
      end
      if (drain_req && drain_ack) begin
        st[h[2:0]] = '0;
        h++;
      end
    end
    m_st <= st;
    m_cmt <= c;
    m_tail <= t;
    m_head <= h;
  end

  always @(posedge clk) begin : compare
    if (chk_on && !rst) begin
      for (int p = 0; p < LD_PORTS; p++) begin
        assert (ld_rsp[p] == exp_q[p]) else begin
          errors++;
          $display("error %s expected %h actual %h", test_name, exp_q[p], ld_rsp[p]);
        end
      end
      assert (full == all_busy() && st_alloc_idx == m_tail[2:0]) else begin
        errors++;
        $display("error %s expected %h actual %h", test_name, {all_busy(), m_tail[2:0]},
                 {full, st_alloc_idx});
      end
      // Req rises with ack low, holds until ack, then drops
      assert (!(drain_req && !req_q && ack_q) && !(req_q && ack_q && drain_req) &&
              !(req_q && !ack_q && !drain_req)) else begin
        errors++;
        $display("drain handshake left the four-phase order");
      end
    end
    req_q <= drain_req;
    ack_q <= drain_ack;
  end

  // Acks each request after 0 to 3 cycles, drops ack once req falls
  always begin : responder
    int e;
    @(posedge clk);
    if (!rst && drain_req && !drain_ack) begin
      repeat ($urandom % 4) @(posedge clk);
      if (idx_q.size() == 0) begin
        errors++;
        $display("drain request seen with no committed store outstanding");
      end else begin
        e = idx_q.pop_front();
        assert (drain_pkt == {m_addr[e], m_data[e]}) else begin
          errors++;
          $display("error %s expected %h actual %h", test_name, {m_addr[e], m_data[e]},
                   drain_pkt);
        end
      end
      drained++;
      drain_ack <= 1'b1;
      do @(posedge clk); while (drain_req);
      drain_ack <= 1'b0;
    end
  end

  task automatic drive(input logic a, input stq_addr_t aa, input logic d, input logic [2:0] di,
                       input logic [63:0] dd, input logic c, input logic x,
                       input ld_req_t l0, input ld_req_t l1);
    @(posedge clk);
    st_alloc_en   <= a;
    st_alloc_addr <= aa;
    st_data_en    <= d;
    st_data_idx   <= di;
    st_data       <= dd;
    commit_en     <= c;
    excpt         <= x;
    ld_req[0]     <= l0;
    ld_req[1]     <= l1;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(0, NO_A, 0, 0, 0, 0, 0, NO_LD, NO_LD);
  endtask

  function automatic ld_req_t mk_ld(input logic [31:0] a, input logic [7:0] b);
    ld_req_t r;
    r = '0;
    r.en = 1'b1;
    r.addr.addr = a;
    r.addr.bytes = b;
    return r;
  endfunction

  // Flags are {hit0, stall0, hit1, stall1}
  task automatic load_check(input ld_req_t l0, input ld_req_t l1, input logic [3:0] hs);
    drive(0, NO_A, 0, 0, 0, 0, 0, l0, l1);
    idle(1);
    @(posedge clk);
    assert ({ld_rsp[0].hit, ld_rsp[0].stall, ld_rsp[1].hit, ld_rsp[1].stall} == hs) else begin
      errors++;
      $display("error %s expected %b actual %b", test_name, hs,
               {ld_rsp[0].hit, ld_rsp[0].stall, ld_rsp[1].hit, ld_rsp[1].stall});
    end
  endtask

  task automatic store(input logic [31:0] a, input logic [7:0] b, input logic [2:0] i,
                       input logic [63:0] d);
    drive(1, {a, b}, 0, 0, 0, 0, 0, NO_LD, NO_LD);
    drive(0, NO_A, 1, i, d, 0, 0, NO_LD, NO_LD);
  endtask

  task automatic drain_all();
    while (m_head != m_cmt || drain_req) idle(1);
    idle(2);
  endtask

  initial begin : watchdog
    #(TEST_CYCLES * 4 * 4);
    $display("timeout after %0d cycles with %0d errors", TEST_CYCLES * 4, errors);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [2:0] di;
    logic a, d, c, x;
    void'($urandom(32'h7183));
    rst = 1'b1;
    {st_alloc_en, st_data_en, commit_en, excpt, drain_ack} = '0;
    st_alloc_addr = '0;
    st_data_idx = '0;
    st_data = '0;
    ld_req[0] = '0;
    ld_req[1] = '0;
    errors = 0;
    drained = 0;
    test_name = "full_forward";
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    drive(1, {32'h100, 8'hff}, 0, 0, 0, 0, 0, NO_LD, NO_LD);
    load_check(mk_ld(32'h100, 8'h0f), NO_LD, 4'b0100); // No data yet
    drive(0, NO_A, 1, 0, 64'h1111_2222_3333_4444, 0, 0, NO_LD, NO_LD);
    load_check(mk_ld(32'h100, 8'h0f), NO_LD, 4'b1000);

    test_name = "partial_overlap";
    store(32'h200, 8'h0f, 1, 64'h5555);
    load_check(mk_ld(32'h200, 8'h3c), mk_ld(32'h300, 8'hff), 4'b0100);

    test_name = "youngest_wins";
    store(32'h400, 8'hff, 2, 64'haaaa);
    store(32'h400, 8'h0f, 3, 64'hbbbb);
    store(32'h400, 8'hf0, 4, 64'hcccc);
    load_check(mk_ld(32'h400, 8'h03), mk_ld(32'h400, 8'h18), 4'b1001);

    test_name = "commit_drain";
    store(32'h500, 8'hff, 5, 64'hdddd);
    store(32'h600, 8'hff, 6, 64'heeee);
    store(32'h700, 8'hff, 7, 64'hffff);
    idle(1);
    @(posedge clk);
    assert (full) else begin
      errors++;
      $display("queue not full with all eight entries allocated");
    end
    repeat (8) drive(0, NO_A, 0, 0, 0, 1, 0, NO_LD, NO_LD);
    drain_all();
    assert (drained == 8 && !full) else begin
      errors++;
      $display("error %s expected %h actual %h", test_name, 8, drained);
    end

    test_name = "exception";
    for (int i = 0; i < 5; i++) store(32'h800 + i, 8'hff, i, 64'h9000 + i);
    repeat (2) drive(0, NO_A, 0, 0, 0, 1, 0, NO_LD, NO_LD);
    drive(0, NO_A, 0, 0, 0, 0, 1, NO_LD, NO_LD);
    idle(1);
    @(posedge clk);
    assert (st_alloc_idx == 3'd2) else begin
      errors++;
      $display("error %s expected %h actual %h", test_name, 3'd2, st_alloc_idx);
    end
    load_check(mk_ld(32'h802, 8'hff), mk_ld(32'h804, 8'hff), 4'b0000);
    load_check(mk_ld(32'h803, 8'hff), NO_LD, 4'b0000);
    drain_all();

    test_name = "random_mix";
    for (int k = 0; k < 200; k++) begin
      @(negedge clk); // Mirror has taken the last edge
      di = $urandom % N;
      x = ($urandom % 25) == 0;
      a = ($urandom % 2) && !x && (4'(m_tail - m_head) < N);
      d = ($urandom % 2) && m_st[di].busy && !m_st[di].data_ok;
      c = ($urandom % 3) == 0 && m_cmt != m_tail;
      drive(a, {32'($urandom % 4), 8'($urandom)}, d, di, {$urandom, $urandom}, c, x,
            $urandom % 2 ? mk_ld($urandom % 4, $urandom) : NO_LD,
            mk_ld($urandom % 4, $urandom));
      drive(0, NO_A, 0, 0, 0, 0, 0, mk_ld($urandom % 4, $urandom),
            mk_ld($urandom % 4, $urandom));
    end
    drive(0, NO_A, 0, 0, 0, 0, 1, NO_LD, NO_LD); // Flush what never committed
    idle(1);
    for (int e = 0; e < N; e++) begin
      if (m_st[e].busy && !m_st[e].data_ok) begin
        drive(0, NO_A, 1, e, 64'h7700 + e, 0, 0, NO_LD, NO_LD);
        idle(1);
      end
    end
    drain_all();
    assert (idx_q.size() == 0) else begin
      errors++;
      $display("committed stores left undrained at the end of the run");
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/stq_alloc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_alloc_ctrl
  import stq_cfg_pkg::*, stq_types_pkg::*;
#(
  parameter  int NUM_ENTRIES = 8,
  localparam int IDX_W       = $clog2(NUM_ENTRIES)
) (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   st_alloc_en,
  input  stq_addr_t              st_alloc_addr,
  input  logic                   st_data_en,
  input  logic [IDX_W-1:0]       st_data_idx,
  input  logic [STQ_DATA_W-1:0]  st_data,
  input  logic                   commit_en,
  input  logic                   excpt,

  input  stq_state_t             state [NUM_ENTRIES],
  input  stq_addr_t              entry_addr [NUM_ENTRIES],
  input  logic [STQ_DATA_W-1:0]  entry_data [NUM_ENTRIES],
  input  logic                   drain_ack,

  output logic [NUM_ENTRIES-1:0] wr_en,
  output stq_addr_t              wr_addr,
  output logic [NUM_ENTRIES-1:0] data_en,
  output logic [STQ_DATA_W-1:0]  wr_data,
  output logic [NUM_ENTRIES-1:0] commit_set,
  output logic [NUM_ENTRIES-1:0] free_en,
  output logic                   flush,
  output logic [IDX_W-1:0]       tail,
  output logic [IDX_W-1:0]       st_alloc_idx,
  output logic                   full,
  output logic                   drain_req,
  output drain_pkt_t             drain_pkt
);

  // Pointers carry one wrap bit above the index
  logic [IDX_W:0] head_q, cmt_q, tail_q, cmt_nxt;
  logic [IDX_W-1:0] head_idx, cmt_idx;
  logic alloc_ok, commit_ok, drain_done, head_ready;

  assign head_idx     = head_q[IDX_W-1:0];
  assign cmt_idx      = cmt_q[IDX_W-1:0];
  assign tail         = tail_q[IDX_W-1:0];
  assign st_alloc_idx = tail;

  assign full = (head_q[IDX_W] != tail_q[IDX_W]) && (head_idx == tail);

  // An allocation racing an exception is younger and gets dropped
  assign alloc_ok  = st_alloc_en && !full && !excpt;
  assign commit_ok = commit_en && (cmt_q != tail_q);
  assign cmt_nxt   = cmt_q + (IDX_W+1)'(commit_ok);

  assign wr_en      = alloc_ok ? NUM_ENTRIES'(1) << tail : '0;
  assign wr_addr    = st_alloc_addr;
  assign data_en    = st_data_en ? NUM_ENTRIES'(1) << st_data_idx : '0;
  assign wr_data    = st_data;
  assign commit_set = commit_ok ? NUM_ENTRIES'(1) << cmt_idx : '0;
  assign flush      = excpt;

  assign head_ready = state[head_idx].busy && state[head_idx].committed &&
                      state[head_idx].data_ok;
  assign drain_done = drain_req && drain_ack;
  assign free_en    = drain_done ? NUM_ENTRIES'(1) << head_idx : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q    <= '0;
      cmt_q     <= '0;
      tail_q    <= '0;
      drain_req <= 1'b0;
    end else begin
      cmt_q <= cmt_nxt;
      if (excpt) begin
        tail_q <= cmt_nxt; // Back to the oldest uncommitted slot
      end else if (alloc_ok) begin
        tail_q <= tail_q + 1'b1;
      end
      if (drain_done) begin
        head_q <= head_q + 1'b1;
      end
      // Four-phase: raise only once ack is back low
      if (!drain_req) begin
        drain_req <= head_ready && !drain_ack;
      end else if (drain_ack) begin
        drain_req <= 1'b0;
      end
    end
  end

  // Captured once per request and held until ack
  always_ff @(posedge clk) begin
    if (!drain_req && head_ready && !drain_ack) begin
      drain_pkt.addr <= entry_addr[head_idx];
      drain_pkt.data <= entry_data[head_idx];
    end
  end

  a_no_alloc_full: assert property (
    @(posedge clk) disable iff (rst)
    st_alloc_en |-> !full
  );

  a_drain_hold: assert property (
    @(posedge clk) disable iff (rst)
    (drain_req && !drain_ack) |=> (drain_req && $stable(drain_pkt) &&
                                   drain_pkt.addr == entry_addr[head_idx] &&
                                   drain_pkt.data == entry_data[head_idx])
  );

  a_commit_tail: assert property (
    @(posedge clk) disable iff (rst)
    commit_en |-> (cmt_q != tail_q)
  );

endmodule

`default_nettype wire

// ==== hw/stq_cfg_pkg.sv ====
`default_nettype none

// Widths shared by the queue, its controller and the forwarding logic
package stq_cfg_pkg;

  // Word address of a store or load
  localparam int STQ_ADDR_W = 32;

  localparam int STQ_BYTES = 8; // Bytes per word, also byte mask width

  localparam int STQ_DATA_W = 64;

  // Load check ports, each looked up every cycle
  localparam int LD_PORTS = 2;

endpackage

`default_nettype wire

// ==== hw/stq_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_entry
  import stq_cfg_pkg::*, stq_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  wr_en,
  input  stq_addr_t             wr_addr,
  input  logic                  data_en,
  input  logic [STQ_DATA_W-1:0] wr_data,
  input  logic                  commit_set,
  input  logic                  free_en,
  input  logic                  flush,

  input  ld_req_t               ld_req [LD_PORTS],

  output stq_state_t            state,
  output stq_addr_t             addr,
  output logic [STQ_DATA_W-1:0] data,
  output logic [LD_PORTS-1:0]   overlap,
  output logic [LD_PORTS-1:0]   covers
);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= '0;
    end else begin
      if (wr_en) begin
        state.busy      <= 1'b1;
        state.data_ok   <= 1'b0;
        state.committed <= 1'b0;
      end
      if (data_en) begin
        state.data_ok <= 1'b1;
      end
      if (commit_set) begin
        state.committed <= 1'b1;
      end
      // A commit in the same cycle as the exception survives it
      if (flush && !state.committed && !commit_set) begin
        state.busy <= 1'b0;
      end
      if (free_en) begin // Drained to the cache
        state.busy      <= 1'b0;
        state.committed <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      addr <= wr_addr;
    end
    if (data_en) begin
      data <= wr_data;
    end
  end

  // Per load port match against this store
  always_comb begin
    for (int p = 0; p < LD_PORTS; p++) begin
      overlap[p] = state.busy && ld_req[p].en &&
                   (ld_req[p].addr.addr == addr.addr) &&
                   (|(ld_req[p].addr.bytes & addr.bytes));
      // Load bytes must all come from this store
      covers[p]  = overlap[p] && state.data_ok &&
                   ((ld_req[p].addr.bytes & ~addr.bytes) == '0);
    end
  end

  // Data for an entry is sent only after its allocation has landed
  a_wr_data_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(wr_en && data_en)
  );

endmodule

`default_nettype wire

// ==== hw/stq_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_entry_array
  import stq_cfg_pkg::*, stq_types_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                   clk,
  input  logic                   rst,

  input  logic [NUM_ENTRIES-1:0] wr_en,
  input  stq_addr_t              wr_addr,
  input  logic [NUM_ENTRIES-1:0] data_en,
  input  logic [STQ_DATA_W-1:0]  wr_data,
  input  logic [NUM_ENTRIES-1:0] commit_set,
  input  logic [NUM_ENTRIES-1:0] free_en,
  input  logic                   flush,

  input  ld_req_t                ld_req [LD_PORTS],

  output stq_state_t             state [NUM_ENTRIES],
  output stq_addr_t              addr [NUM_ENTRIES],
  output logic [STQ_DATA_W-1:0]  data [NUM_ENTRIES],
  output logic [NUM_ENTRIES-1:0] overlap [LD_PORTS],
  output logic [NUM_ENTRIES-1:0] covers [LD_PORTS]
);

  logic [LD_PORTS-1:0] ov_e [NUM_ENTRIES]; // Per entry, per port
  logic [LD_PORTS-1:0] cv_e [NUM_ENTRIES];

  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    stq_entry u_entry (
      .clk        (clk),
      .rst        (rst),
      .wr_en      (wr_en[e]),
      .wr_addr    (wr_addr),
      .data_en    (data_en[e]),
      .wr_data    (wr_data),
      .commit_set (commit_set[e]),
      .free_en    (free_en[e]),
      .flush      (flush),
      .ld_req     (ld_req),
      .state      (state[e]),
      .addr       (addr[e]),
      .data       (data[e]),
      .overlap    (ov_e[e]),
      .covers     (cv_e[e])
    );
  end

  // Regroup by port so each port sees one vector over all entries
  always_comb begin
    for (int p = 0; p < LD_PORTS; p++) begin
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        overlap[p][e] = ov_e[e][p];
        covers[p][e]  = cv_e[e][p];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/stq_fwd_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_fwd_select
  import stq_cfg_pkg::*, stq_types_pkg::*;
#(
  parameter  int NUM_ENTRIES = 8,
  localparam int IDX_W       = $clog2(NUM_ENTRIES)
) (
  input  logic                   clk,
  input  logic                   rst,

  input  logic [LD_PORTS-1:0]    ld_en,
  input  logic [NUM_ENTRIES-1:0] overlap [LD_PORTS],
  input  logic [NUM_ENTRIES-1:0] covers [LD_PORTS],
  input  logic [STQ_DATA_W-1:0]  entry_data [NUM_ENTRIES],
  input  logic [IDX_W-1:0]       tail,

  output ld_rsp_t                ld_rsp [LD_PORTS]
);

  logic [NUM_ENTRIES-1:0] rot [LD_PORTS]; // Bit 0 is the youngest store
  logic [IDX_W-1:0]       sel [LD_PORTS];
  logic [LD_PORTS-1:0]    found;

  logic [LD_PORTS-1:0]    rsp_valid, rsp_hit, rsp_stall;
  logic [STQ_DATA_W-1:0]  rsp_data [LD_PORTS];

  always_comb begin
    for (int p = 0; p < LD_PORTS; p++) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        rot[p][i] = overlap[p][IDX_W'(tail - 1 - i)];
      end
      found[p] = |rot[p];
      sel[p]   = '0;
      // Walk from oldest to youngest so the lowest set bit wins
      for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
        if (rot[p][i]) begin
          sel[p] = IDX_W'(tail - 1 - i);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= '0;
    end else begin
      rsp_valid <= ld_en;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < LD_PORTS; p++) begin
      rsp_hit[p]   <= found[p] && covers[p][sel[p]];
      rsp_stall[p] <= found[p] && !covers[p][sel[p]];
      rsp_data[p]  <= (found[p] && covers[p][sel[p]]) ? entry_data[sel[p]] : '0;
    end
  end

  always_comb begin
    for (int p = 0; p < LD_PORTS; p++) begin
      ld_rsp[p].valid = rsp_valid[p];
      ld_rsp[p].hit   = rsp_hit[p];
      ld_rsp[p].stall = rsp_stall[p];
      ld_rsp[p].data  = rsp_data[p];
    end
  end

endmodule

`default_nettype wire

// ==== hw/stq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_top
  import stq_cfg_pkg::*, stq_types_pkg::*;
#(
  parameter  int NUM_ENTRIES = 8,
  localparam int IDX_W       = $clog2(NUM_ENTRIES)
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  st_alloc_en,
  input  stq_addr_t             st_alloc_addr,
  output logic [IDX_W-1:0]      st_alloc_idx,
  output logic                  full,

  input  logic                  st_data_en,
  input  logic [IDX_W-1:0]      st_data_idx,
  input  logic [STQ_DATA_W-1:0] st_data,

  input  logic                  commit_en,
  input  logic                  excpt,

  input  ld_req_t               ld_req [LD_PORTS],
  output ld_rsp_t               ld_rsp [LD_PORTS],

  output logic                  drain_req,
  output drain_pkt_t            drain_pkt,
  input  logic                  drain_ack
);

  logic [NUM_ENTRIES-1:0] wr_en, data_en, commit_set, free_en;
  stq_addr_t              wr_addr;
  logic [STQ_DATA_W-1:0]  wr_data;
  logic                   flush;
  logic [IDX_W-1:0]       tail;

  stq_state_t             state [NUM_ENTRIES];
  stq_addr_t              entry_addr [NUM_ENTRIES];
  logic [STQ_DATA_W-1:0]  entry_data [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] overlap [LD_PORTS];
  logic [NUM_ENTRIES-1:0] covers [LD_PORTS];
  logic [LD_PORTS-1:0]    ld_en;

  always_comb begin
    for (int p = 0; p < LD_PORTS; p++) begin
      ld_en[p] = ld_req[p].en;
    end
  end

  stq_alloc_ctrl #(.NUM_ENTRIES(NUM_ENTRIES)) u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .st_alloc_en   (st_alloc_en),
    .st_alloc_addr (st_alloc_addr),
    .st_data_en    (st_data_en),
    .st_data_idx   (st_data_idx),
    .st_data       (st_data),
    .commit_en     (commit_en),
    .excpt         (excpt),
    .state         (state),
    .entry_addr    (entry_addr),
    .entry_data    (entry_data),
    .drain_ack     (drain_ack),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .data_en       (data_en),
    .wr_data       (wr_data),
    .commit_set    (commit_set),
    .free_en       (free_en),
    .flush         (flush),
    .tail          (tail),
    .st_alloc_idx  (st_alloc_idx),
    .full          (full),
    .drain_req     (drain_req),
    .drain_pkt     (drain_pkt)
  );

  stq_entry_array #(.NUM_ENTRIES(NUM_ENTRIES)) u_array (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .data_en    (data_en),
    .wr_data    (wr_data),
    .commit_set (commit_set),
    .free_en    (free_en),
    .flush      (flush),
    .ld_req     (ld_req),
    .state      (state),
    .addr       (entry_addr),
    .data       (entry_data),
    .overlap    (overlap),
    .covers     (covers)
  );

  stq_fwd_select #(.NUM_ENTRIES(NUM_ENTRIES)) u_fwd (
    .clk        (clk),
    .rst        (rst),
    .ld_en      (ld_en),
    .overlap    (overlap),
    .covers     (covers),
    .entry_data (entry_data),
    .tail       (tail),
    .ld_rsp     (ld_rsp)
  );

endmodule

`default_nettype wire

// ==== hw/stq_types_pkg.sv ====
`default_nettype none

package stq_types_pkg;
  import stq_cfg_pkg::*;

  typedef struct packed {
    logic [STQ_ADDR_W-1:0] addr;
    logic [STQ_BYTES-1:0]  bytes; // Byte enables within the word
  } stq_addr_t;

  // One load lookup, presented for a single cycle
  typedef struct packed {
    logic                  en;
    stq_addr_t             addr;
    logic [STQ_DATA_W-1:0] data;
  } ld_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  hit;   // Full forward
    logic                  stall; // Partial overlap or data missing
    logic [STQ_DATA_W-1:0] data;
  } ld_rsp_t;

  typedef struct packed {
    logic busy;
    logic data_ok;
    logic committed;
  } stq_state_t;

  // Retired store on its way to the cache
  typedef struct packed {
    stq_addr_t             addr;
    logic [STQ_DATA_W-1:0] data;
  } drain_pkt_t;

endpackage

`default_nettype wire

// ==== stq_top.f ====
hw/stq_cfg_pkg.sv
hw/stq_types_pkg.sv
hw/stq_entry.sv
hw/stq_entry_array.sv
hw/stq_alloc_ctrl.sv
hw/stq_fwd_select.sv
hw/stq_top.sv
dv/stq_tb.sv
